/* project.f */
+incdir+tests
src/axil_pkg.sv
src/axil_target_mux.sv
src/axil_mem_target.sv
src/axil_mem_subsys.sv
tests/tb_axil_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_axil_mem_subsys
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f project.f --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0

/* tests/tb_axil_tasks.svh */
//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

logic [data_w-1:0] la_shadow [mem_depth];
logic [data_w-1:0] up_shadow [mem_depth];
int unsigned       lcg_state = 73;

// Read in flight that the checker follows
logic              read_open = 1'b0;
target_e           rd_target = tgt_none;
logic [addr_w-1:0] rd_addr   = '0;

initial begin
	for (int i = 0; i < mem_depth; i++) begin
		la_shadow[i] = data_w'(i);	// Every word starts at its index
		up_shadow[i] = data_w'(i);
	end
end

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic int rand_range(input int lo, input int hi);
	return lo + int'((lcg_next() >> 8) % $unsigned(hi - lo + 1));
endfunction

// Only the low 8 address bits pick the word
function automatic logic [data_w-1:0] expected_word(input target_e tgt,
	input logic [addr_w-1:0] addr);
	return (tgt == tgt_up) ? up_shadow[addr[mem_aw-1:0]] : la_shadow[addr[mem_aw-1:0]];
endfunction

task automatic record_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
	if (target_sel == tgt_up) begin
		up_shadow[addr[mem_aw-1:0]] = data;
	end else begin
		la_shadow[addr[mem_aw-1:0]] = data;
	end
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_data(input string name, input logic [data_w-1:0] expected,
	input logic [data_w-1:0] actual);
	if (actual !== expected) begin
		data_errors++;
		$display("[ERROR] %0t: %s expected %h, got %h", $time, name, expected, actual);
	end
endtask

task automatic check_idle(input axil_rsp_t actual);
	axil_rsp_t expected = '0;
	if (actual !== expected) begin
		idle_errors++;
		$display("[ERROR] %0t: rsp expected %h, got %h", $time, expected, actual);
	end
endtask

task automatic report_failure(input string what);
	proto_errors++;
	$display("[ERROR] %0t: %s", $time, what);
endtask

//////////////////////////////////////////////////////////////////////
// Bus master
//////////////////////////////////////////////////////////////////////

task automatic step_cycle();
	@(posedge axi_clk);
	#1;
endtask

task automatic select_target(input target_e tgt);
	target_sel = tgt;
	step_cycle();
endtask

task automatic do_read(input logic [addr_w-1:0] addr, input int hold);
	rd_target   = target_sel;
	rd_addr     = addr;
	read_open   = 1'b1;
	reads_issued++;
	req.arvalid = 1'b1;
	req.araddr  = addr;
	step_cycle();
	while (!rsp.arready) begin
		step_cycle();
	end
	step_cycle();	// arready seen at this edge
	req.arvalid = 1'b0;
	while (!rsp.rvalid) begin
		step_cycle();
	end
	for (int i = 0; i < hold; i++) begin
		step_cycle();
		if (!rsp.rvalid) begin
			report_failure("rvalid dropped while rready was still low");
		end
	end
	req.rready = 1'b1;
	step_cycle();
	req.rready = 1'b0;
	read_open  = 1'b0;
	check_idle(rsp);	// rvalid low and rdata back to zero
endtask

task automatic write_together(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
	req.awvalid = 1'b1;
	req.awaddr  = addr;
	req.wvalid  = 1'b1;
	req.wdata   = data;
	step_cycle();
	while (!rsp.awready) begin
		step_cycle();
	end
	if (!rsp.wready) begin
		report_failure("wready did not come together with awready");
	end
	step_cycle();
	req.awvalid = 1'b0;
	req.wvalid  = 1'b0;
	check_idle(rsp);	// Both readies were single pulses
	record_write(addr, data);
endtask

task automatic write_addr_first(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
	input int delay);
	req.awvalid = 1'b1;
	req.awaddr  = addr;
	req.wvalid  = 1'b0;
	req.wdata   = '0;
	step_cycle();
	while (!rsp.awready) begin
		step_cycle();
	end
	if (rsp.wready) begin
		report_failure("wready came before any write data");
	end
	step_cycle();
	req.awvalid = 1'b0;
	repeat (delay) step_cycle();	// Target parked waiting for data
	req.wvalid = 1'b1;
	req.wdata  = data;
	step_cycle();
	while (!rsp.wready) begin
		step_cycle();
	end
	step_cycle();
	req.wvalid = 1'b0;
	check_idle(rsp);
	record_write(addr, data);
endtask

/* tests/tb_axil_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_mem_subsys import axil_pkg::*; ();

	localparam int n_random      = 200;
	localparam int max_op_cycles = 12;
	// Random ops plus about 50 directed ones and some margin
	localparam int max_cycles    = (n_random + 50) * max_op_cycles + 2000;

	logic      axi_clk;
	logic      axi_reset_n;
	target_e   target_sel;
	axil_req_t req;
	axil_rsp_t rsp;

	int data_errors   = 0;
	int idle_errors   = 0;
	int proto_errors  = 0;
	int reads_issued  = 0;
	int reads_checked = 0;
	int cycles        = 0;

	`include "tb_axil_tasks.svh"

	axil_mem_subsys dut (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.target_sel  (target_sel),
		.req         (req),
		.rsp         (rsp)
	);

	initial begin
		axi_clk = 1'b0;
		forever #4 axi_clk = ~axi_clk;
	end

	always @(posedge axi_clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: the test did not end within %0d cycles", max_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// rsp is settled at mid-cycle
	always @(negedge axi_clk) begin
		if (read_open && rsp.rvalid) begin
			check_data("rsp.rdata", expected_word(rd_target, rd_addr), rsp.rdata);
			if (req.rready) begin
				reads_checked++;
			end
		end
	end

	initial begin
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
		int                kind;
		req         = '0;
		target_sel  = tgt_none;
		axi_reset_n = 1'b0;
		repeat (2) @(posedge axi_clk);
		#1;
		axi_reset_n = 1'b1;
		step_cycle();
		check_idle(rsp);

		for (int i = 0; i < 4; i++) begin
			addr = addr_w'(i * 85);	// 0, 85, 170, 255
			select_target(tgt_la);
			check_idle(rsp);
			do_read(addr, 0);
			select_target(tgt_up);
			check_idle(rsp);
			do_read(addr, 0);
		end

		// One target written and the other untouched
		select_target(tgt_la);
		write_together(15'h0012, 32'hdead_beef);
		do_read(15'h0012, 0);
		select_target(tgt_up);
		do_read(15'h0012, 0);
		select_target(tgt_la);
		do_read(15'h0012, 0);

		for (int i = 0; i < 4; i++) begin
			addr = addr_w'(64 + i);
			write_addr_first(addr, lcg_next(), rand_range(1, 5));
			do_read(addr, 0);
		end

		for (int i = 0; i < 6; i++) begin
			select_target((i % 2 == 0) ? tgt_la : tgt_up);
			do_read(addr_w'(lcg_next()), rand_range(0, 6));
		end

		// Aliasing
		select_target(tgt_up);
		write_together(15'h00a5, 32'h5a5a_0001);
		do_read(15'h01a5, 2);
		write_addr_first(15'h7f33, 32'h0bad_cafe, 3);
		do_read(15'h0033, 0);

		for (int i = 0; i < n_random; i++) begin
			select_target((rand_range(0, 1) == 0) ? tgt_la : tgt_up);
			addr = addr_w'(lcg_next());
			data = lcg_next();
			kind = rand_range(0, 2);
			case (kind)
				0:       do_read(addr, rand_range(0, 6));
				1:       write_together(addr, data);
				default: write_addr_first(addr, data, rand_range(1, 5));
			endcase
		end

		// Request must go unanswered with nobody selected
		select_target(tgt_none);
		req.arvalid = 1'b1;
		req.araddr  = 15'h0005;
		repeat (8) begin
			step_cycle();
			check_idle(rsp);
		end
		req.arvalid = 1'b0;
		select_target(tgt_la);
		do_read(15'h0005, 0);

		if (reads_checked != reads_issued) begin
			report_failure("not every issued read reached the checker");
		end
		$display("Errors: %0d data, %0d idle, %0d protocol (%0d of %0d reads checked)",
			data_errors, idle_errors, proto_errors, reads_checked, reads_issued);
		if (data_errors + idle_errors + proto_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/axil_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_subsys import axil_pkg::*; (
	input  logic      axi_clk,
	input  logic      axi_reset_n,
	input  target_e   target_sel,
	input  axil_req_t req,
	output axil_rsp_t rsp
);

	axil_rsp_t la_rsp;
	axil_rsp_t up_rsp;
	logic      la_enable;
	logic      up_enable;

	//////////////////////////////////////////////////////////////////////
	// Logic analyzer target
	//////////////////////////////////////////////////////////////////////

	axil_mem_target la_target (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.enable      (la_enable),
		.req         (req),	// Request fans out to both targets
		.rsp         (la_rsp)
	);

	//////////////////////////////////////////////////////////////////////
	// User project target
	//////////////////////////////////////////////////////////////////////

	axil_mem_target up_target (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.enable      (up_enable),
		.req         (req),
		.rsp         (up_rsp)
	);

	//////////////////////////////////////////////////////////////////////
	// Target select and response mux
	//////////////////////////////////////////////////////////////////////

	// Combinational, adds no cycles to the target timing
	axil_target_mux target_mux (
		.target_sel (target_sel),
		.la_rsp     (la_rsp),
		.up_rsp     (up_rsp),
		.la_enable  (la_enable),
		.up_enable  (up_enable),
		.rsp        (rsp)
	);

endmodule

`default_nettype wire

/* src/axil_mem_target.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_target import axil_pkg::*; (
	input  logic      axi_clk,
	input  logic      axi_reset_n,
	input  logic      enable,
	input  axil_req_t req,
	output axil_rsp_t rsp
);

	axil_state_e       state;
	logic [mem_aw-1:0] addr_q;	// Word index of the open transaction
	logic [data_w-1:0] wdata_q;
	logic              commit_write;

	logic [data_w-1:0] mem [mem_depth];

	// Each word starts out holding its own index
	initial begin
		for (int i = 0; i < mem_depth; i++) begin
			mem[i] = data_w'(i);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM and response registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= st_idle;
			rsp   <= rsp_idle;
		end else if (!enable) begin
			// Deselected, memory keeps its contents
			state <= st_idle;
			rsp   <= rsp_idle;
		end else begin
			case (state)
				st_idle: begin
					if (req.arvalid) begin	// Read wins over write
						rsp.arready <= 1'b1;
						state       <= st_read_data;
					end else if (req.awvalid && req.wvalid) begin
						rsp.awready <= 1'b1;
						rsp.wready  <= 1'b1;
						state       <= st_write_complete;
					end else if (req.awvalid) begin
						rsp.awready <= 1'b1;
						state       <= st_write_data;
					end
				end

				st_read_data: begin
					rsp.arready <= 1'b0;
					rsp.rdata   <= mem[addr_q];
					rsp.rvalid  <= 1'b1;
					state       <= st_read_complete;
				end

				st_read_complete: begin
					// rvalid and rdata hold under back-pressure
					if (req.rready) begin
						rsp.rdata  <= '0;
						rsp.rvalid <= 1'b0;
						state      <= st_idle;
					end
				end

				st_write_data: begin
					rsp.awready <= 1'b0;
					if (req.wvalid) begin	// Data trails the address
						rsp.wready <= 1'b1;
						state      <= st_write_complete;
					end
				end

				st_write_complete: begin
					rsp.awready <= 1'b0;
					rsp.wready  <= 1'b0;
					state       <= st_idle;
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and write data capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge axi_clk) begin
		if (enable) begin
			case (state)
				st_idle: begin
					if (req.arvalid) begin
						addr_q <= mem_index(req.araddr);
					end else if (req.awvalid) begin
						addr_q  <= mem_index(req.awaddr);
						wdata_q <= req.wdata;	// Only kept when wvalid came along
					end
				end

				st_write_data: begin
					if (req.wvalid) begin
						wdata_q <= req.wdata;
					end
				end

				default: begin
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory write port
	//////////////////////////////////////////////////////////////////////

	// One cycle after both readies went out
	assign commit_write = enable && (state == st_write_complete);

	always_ff @(posedge axi_clk) begin
		if (commit_write) begin
			mem[addr_q] <= wdata_q;
		end
	end

endmodule

`default_nettype wire

/* src/axil_target_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_target_mux import axil_pkg::*; (
	input  target_e   target_sel,
	input  axil_rsp_t la_rsp,
	input  axil_rsp_t up_rsp,
	output logic      la_enable,
	output logic      up_enable,
	output axil_rsp_t rsp
);

	//////////////////////////////////////////////////////////////////////
	// Select decode
	//////////////////////////////////////////////////////////////////////

	// One-hot, or both low for tgt_none
	always_comb begin
		la_enable = 1'b0;
		up_enable = 1'b0;
		case (target_sel)
			tgt_la: begin
				la_enable = 1'b1;
			end
			tgt_up: begin
				up_enable = 1'b1;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Response return path
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (target_sel)
			tgt_la: begin
				rsp = la_rsp;
			end
			tgt_up: begin
				rsp = up_rsp;
			end
			default: begin
				rsp = rsp_idle;	// Nobody answers
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/axil_pkg.sv */
`default_nettype none

package axil_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and memory geometry
	//////////////////////////////////////////////////////////////////////

	localparam int addr_w    = 15;
	localparam int data_w    = 32;
	localparam int mem_depth = 256;
	localparam int mem_aw    = $clog2(mem_depth);	// Low part of the bus address

	//////////////////////////////////////////////////////////////////////
	// Bus bundles
	//////////////////////////////////////////////////////////////////////

	// Master to target, 66 bits
	typedef struct packed {
		logic              awvalid;
		logic [addr_w-1:0] awaddr;
		logic              wvalid;
		logic [data_w-1:0] wdata;
		logic              arvalid;
		logic [addr_w-1:0] araddr;
		logic              rready;
	} axil_req_t;

	// Target to master, 36 bits
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              arready;
		logic [data_w-1:0] rdata;
		logic              rvalid;
	} axil_rsp_t;

	localparam axil_rsp_t rsp_idle = '0;	// Idle or deselected target

	//////////////////////////////////////////////////////////////////////
	// State and select encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		st_idle           = 3'd0,
		st_read_data      = 3'd1,
		st_read_complete  = 3'd2,
		st_write_data     = 3'd3,
		st_write_complete = 3'd4
	} axil_state_e;

	typedef enum logic [1:0] {
		tgt_none = 2'd0,
		tgt_la   = 2'd1,
		tgt_up   = 2'd2
	} target_e;

	// Word index into a target memory, upper address bits alias
	function automatic logic [mem_aw-1:0] mem_index(input logic [addr_w-1:0] addr);
		return addr[mem_aw-1:0];
	endfunction

endpackage

`default_nettype wire
